//--- rtl/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int WORD_BYTES     = WORD_WIDTH / 8;
    localparam int LINE_BYTES     = 16;
    localparam int LINE_WIDTH     = LINE_BYTES * 8;
    localparam int NWAY           = 2;
    localparam int WAY_WIDTH      = 1;
    localparam int NSET           = 16;
    localparam int OFFSET_WIDTH   = 4;
    localparam int INDEX_WIDTH    = 4;
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int WORDS_PER_LINE = LINE_BYTES / WORD_BYTES;
    localparam int LFSR_WIDTH     = 16;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_UNC_LOAD,
        OP_UNC_STORE
    } op_e;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_EVICT_WAIT,
        EX_REFILL_WAIT,
        EX_UNC_WAIT
    } ex_state_e;

    //////////////////////////////////////////////////
    // Ports and pipeline payload
    //////////////////////////////////////////////////
    // All-zero wstrb means a load
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] wdata;
        logic [WORD_BYTES-1:0] wstrb;
        logic                  uncached;
    } cpu_req_t;

    typedef struct packed {
        logic                  valid;
        logic [WORD_WIDTH-1:0] rdata;
    } cpu_rsp_t;

    // Single-word accesses use the line lanes selected by wstrb
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  line;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] wdata;
        logic [LINE_BYTES-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [LINE_WIDTH-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic                             valid;
        op_e                              op;
        cpu_req_t                         req;
        logic                             hit;
        logic [WAY_WIDTH-1:0]             hit_way;
        tag_entry_t [NWAY-1:0]            entry;
        logic [NWAY-1:0][LINE_WIDTH-1:0]  line;
    } stage_t;

endpackage

//--- rtl/dcache_ram.sv
`timescale 1ns/100ps

module dcache_ram (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]                      rd_index_i,
    input  logic [dcache_pkg::NWAY-1:0]                             wr_en_i,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]                      wr_index_i,
    input  dcache_pkg::tag_entry_t                                  wr_entry_i,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]                       wr_line_i,
    output dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]           entry_o,
    output logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_WIDTH-1:0] line_o
);

    logic [dcache_pkg::INDEX_WIDTH-1:0] rd_index_q;
    logic [dcache_pkg::NSET-1:0]        valid_q [dcache_pkg::NWAY];
    logic [dcache_pkg::TAG_WIDTH:0]     meta_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    logic [dcache_pkg::LINE_WIDTH-1:0]  line_mem [dcache_pkg::NWAY][dcache_pkg::NSET];

    // Registered read index, arrays read through it
    always_ff @(posedge clk) begin
        rd_index_q <= rd_index_i;
    end

    // Valid bits live in flops so reset can clear every set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                if (wr_en_i[w]) begin
                    valid_q[w][wr_index_i] <= wr_entry_i.valid;
                end
            end
        end
    end

    // Dirty bit and tag, then line data
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            if (wr_en_i[w]) begin
                meta_mem[w][wr_index_i] <= {wr_entry_i.dirty, wr_entry_i.tag};
                line_mem[w][wr_index_i] <= wr_line_i;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            entry_o[w].valid = valid_q[w][rd_index_q];
            entry_o[w].dirty = meta_mem[w][rd_index_q][dcache_pkg::TAG_WIDTH];
            entry_o[w].tag   = meta_mem[w][rd_index_q][dcache_pkg::TAG_WIDTH-1:0];
            line_o[w]        = line_mem[w][rd_index_q];
        end
    end

endmodule

//--- rtl/dcache_result.sv
`timescale 1ns/100ps

module dcache_result (
    input  logic [dcache_pkg::LINE_WIDTH-1:0] line_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [dcache_pkg::WORD_WIDTH-1:0] wdata_i,
    input  logic [dcache_pkg::WORD_BYTES-1:0] wstrb_i,
    output logic [dcache_pkg::LINE_WIDTH-1:0] line_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0] word_o
);

    logic [dcache_pkg::OFFSET_WIDTH-3:0] word_sel;
    logic [dcache_pkg::WORD_WIDTH-1:0]   merged_word;

    assign word_sel = addr_i[dcache_pkg::OFFSET_WIDTH-1:2];

    // Addressed word before any store bytes land
    assign word_o = line_i[word_sel*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];

    // Byte merge under wstrb
    always_comb begin
        for (int b = 0; b < dcache_pkg::WORD_BYTES; b++) begin
            merged_word[b*8 +: 8] = wstrb_i[b] ? wdata_i[b*8 +: 8] : word_o[b*8 +: 8];
        end
    end

    always_comb begin
        line_o = line_i;
        line_o[word_sel*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH] = merged_word;
    end

endmodule

//--- rtl/dcache_decode.sv
`timescale 1ns/100ps

module dcache_decode (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    accept_i,
    input  logic                                                    hold_i,
    input  dcache_pkg::cpu_req_t                                    req_i,
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]           entry_i,
    input  logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_WIDTH-1:0] line_i,
    output dcache_pkg::stage_t                                      stage_o
);

    logic                               valid_q;
    dcache_pkg::cpu_req_t               req_q;
    logic [dcache_pkg::TAG_WIDTH-1:0]   req_tag;
    logic [dcache_pkg::NWAY-1:0]        way_hit;
    logic [dcache_pkg::WAY_WIDTH-1:0]   hit_way;

    //////////////////////////////////////////////////
    // Stage 2 register
    //////////////////////////////////////////////////
    // Kept while stage 3 is blocked
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept_i) begin
            valid_q <= 1'b1;
        end else if (!hold_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            req_q <= req_i;
        end
    end

    //////////////////////////////////////////////////
    // Tag compare
    //////////////////////////////////////////////////
    assign req_tag = req_q.addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            way_hit[w] = entry_i[w].valid && (entry_i[w].tag == req_tag);
            if (way_hit[w]) begin
                hit_way = w[dcache_pkg::WAY_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        stage_o.valid = valid_q;
        stage_o.req   = req_q;
        case ({req_q.uncached, |req_q.wstrb})
            2'b00:   stage_o.op = dcache_pkg::OP_LOAD;
            2'b01:   stage_o.op = dcache_pkg::OP_STORE;
            2'b10:   stage_o.op = dcache_pkg::OP_UNC_LOAD;
            default: stage_o.op = dcache_pkg::OP_UNC_STORE;
        endcase
        // Uncached accesses always go to memory
        stage_o.hit     = (|way_hit) && !req_q.uncached;
        stage_o.hit_way = hit_way;
        // Both ways travel along, stage 3 picks the victim
        stage_o.entry   = entry_i;
        stage_o.line    = line_i;
    end

endmodule

//--- rtl/dcache_execute.sv
`timescale 1ns/100ps

module dcache_execute (
    input  logic                                 clk,
    input  logic                                 rst,
    input  dcache_pkg::stage_t                   stage_i,
    input  dcache_pkg::mem_rsp_t                 mem_rsp_i,
    output dcache_pkg::mem_req_t                 mem_req_o,
    output dcache_pkg::cpu_rsp_t                 rsp_o,
    output logic                                 busy_o,
    output logic [dcache_pkg::NWAY-1:0]          wr_en_o,
    output logic [dcache_pkg::INDEX_WIDTH-1:0]   wr_index_o,
    output dcache_pkg::tag_entry_t               wr_entry_o,
    output logic [dcache_pkg::LINE_WIDTH-1:0]    wr_line_o
);

    dcache_pkg::stage_t                 s3_q;
    dcache_pkg::ex_state_e              state_q;
    dcache_pkg::ex_state_e              state_d;
    dcache_pkg::mem_req_t               mem_req_d;
    logic [dcache_pkg::LFSR_WIDTH-1:0]  lfsr_q;
    logic [dcache_pkg::WAY_WIDTH-1:0]   victim;
    logic [dcache_pkg::WAY_WIDTH-1:0]   victim_q;
    logic                               victim_dirty;
    logic                               is_store;
    logic                               done;
    logic [dcache_pkg::INDEX_WIDTH-1:0] index;
    logic [dcache_pkg::TAG_WIDTH-1:0]   tag;
    logic [dcache_pkg::LINE_WIDTH-1:0]  src_line;
    logic [dcache_pkg::LINE_WIDTH-1:0]  merged_line;
    logic [dcache_pkg::WORD_WIDTH-1:0]  word;

    //////////////////////////////////////////////////
    // Stage 3 register, FSM and LFSR
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= dcache_pkg::EX_IDLE;
            lfsr_q          <= '1;
            s3_q.valid      <= 1'b0;
            mem_req_o.valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            lfsr_q    <= {lfsr_q[dcache_pkg::LFSR_WIDTH-2:0],
                          lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            mem_req_o <= mem_req_d;
            if (!busy_o) begin
                s3_q <= stage_i;
            end else if (done) begin
                s3_q.valid <= 1'b0;
            end
        end
    end

    // Victim frozen once the miss leaves idle
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::EX_IDLE) begin
            victim_q <= victim;
        end
    end

    assign index        = s3_q.req.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign tag          = s3_q.req.addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
    assign is_store     = (s3_q.op == dcache_pkg::OP_STORE) || (s3_q.op == dcache_pkg::OP_UNC_STORE);
    assign victim       = lfsr_q[dcache_pkg::WAY_WIDTH-1:0];
    assign victim_dirty = s3_q.entry[victim].valid && s3_q.entry[victim].dirty;
    assign done         = mem_rsp_i.valid && (state_q == dcache_pkg::EX_REFILL_WAIT ||
                                              state_q == dcache_pkg::EX_UNC_WAIT);
    assign busy_o       = (state_q != dcache_pkg::EX_IDLE) || (s3_q.valid && !s3_q.hit);

    // Hit line while idle, memory line otherwise
    assign src_line = (state_q == dcache_pkg::EX_IDLE) ? s3_q.line[s3_q.hit_way] : mem_rsp_i.rdata;

    dcache_result result_i (
        .line_i  (src_line),
        .addr_i  (s3_q.req.addr),
        .wdata_i (s3_q.req.wdata),
        .wstrb_i (s3_q.req.wstrb),
        .line_o  (merged_line),
        .word_o  (word)
    );

    //////////////////////////////////////////////////
    // Memory traffic
    //////////////////////////////////////////////////
    always_comb begin
        state_d        = state_q;
        mem_req_d      = '0;
        // Default is the refill read of the request line
        mem_req_d.line = 1'b1;
        mem_req_d.addr = {tag, index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
        case (state_q)
            dcache_pkg::EX_IDLE: begin
                if (s3_q.valid && !s3_q.hit) begin
                    mem_req_d.valid = 1'b1;
                    if (s3_q.req.uncached) begin
                        mem_req_d.write = is_store;
                        mem_req_d.line  = 1'b0;
                        mem_req_d.addr  = s3_q.req.addr;
                        mem_req_d.wdata = {dcache_pkg::WORDS_PER_LINE{s3_q.req.wdata}};
                        mem_req_d.wstrb =
                            {{(dcache_pkg::LINE_BYTES - dcache_pkg::WORD_BYTES){1'b0}},
                             s3_q.req.wstrb} << {s3_q.req.addr[dcache_pkg::OFFSET_WIDTH-1:2], 2'b00};
                        state_d = dcache_pkg::EX_UNC_WAIT;
                    end else if (victim_dirty) begin
                        // Full line write back of the victim first
                        mem_req_d.write = 1'b1;
                        mem_req_d.addr  = {s3_q.entry[victim].tag, index,
                                           {dcache_pkg::OFFSET_WIDTH{1'b0}}};
                        mem_req_d.wdata = s3_q.line[victim];
                        mem_req_d.wstrb = '1;
                        state_d = dcache_pkg::EX_EVICT_WAIT;
                    end else begin
                        state_d = dcache_pkg::EX_REFILL_WAIT;
                    end
                end
            end
            dcache_pkg::EX_EVICT_WAIT: begin
                if (mem_rsp_i.valid) begin
                    mem_req_d.valid = 1'b1;
                    state_d = dcache_pkg::EX_REFILL_WAIT;
                end
            end
            default: begin
                if (mem_rsp_i.valid) begin
                    state_d = dcache_pkg::EX_IDLE;
                end
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Array writes and CPU response
    //////////////////////////////////////////////////
    always_comb begin
        wr_en_o    = '0;
        wr_index_o = index;
        wr_line_o  = merged_line;
        wr_entry_o = '{valid: 1'b1, dirty: is_store, tag: tag};
        if (state_q == dcache_pkg::EX_IDLE && s3_q.valid && s3_q.hit && is_store) begin
            wr_en_o[s3_q.hit_way] = 1'b1;
        end else if (done && state_q == dcache_pkg::EX_REFILL_WAIT) begin
            // Write-allocate, store bytes already merged
            wr_en_o[victim_q] = 1'b1;
        end
    end

    always_comb begin
        rsp_o.valid = done || (state_q == dcache_pkg::EX_IDLE && s3_q.valid && s3_q.hit);
        rsp_o.rdata = (rsp_o.valid && !is_store) ? word : '0;
    end

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid_i,
    input  dcache_pkg::cpu_req_t req_i,
    output logic                 ready_o,
    output dcache_pkg::cpu_rsp_t rsp_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);

    logic                                              accept;
    logic                                              busy;
    logic [1:0]                                        bubble_q;
    logic [dcache_pkg::INDEX_WIDTH-1:0]                rd_index;
    dcache_pkg::stage_t                                stage;
    dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]     entry;
    logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_WIDTH-1:0] line;
    logic [dcache_pkg::NWAY-1:0]                       wr_en;
    logic [dcache_pkg::INDEX_WIDTH-1:0]                wr_index;
    dcache_pkg::tag_entry_t                            wr_entry;
    logic [dcache_pkg::LINE_WIDTH-1:0]                 wr_line;

    //////////////////////////////////////////////////
    // Stage 1 and CPU handshake
    //////////////////////////////////////////////////
    assign ready_o = !busy && (bubble_q == 2'd0);
    assign accept  = req_valid_i && ready_o;

    // Two idle cycles after a store so the next read sees its write
    always_ff @(posedge clk) begin
        if (rst) begin
            bubble_q <= 2'd0;
        end else if (accept && (|req_i.wstrb)) begin
            bubble_q <= 2'd2;
        end else if (bubble_q != 2'd0) begin
            bubble_q <= bubble_q - 2'd1;
        end
    end

    // Held item keeps re-reading its set, so refills show up in stage 2
    assign rd_index = accept ? req_i.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH]
                             : stage.req.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];

    dcache_ram ram_i (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_entry_i (wr_entry),
        .wr_line_i  (wr_line),
        .entry_o    (entry),
        .line_o     (line)
    );

    dcache_decode decode_i (
        .clk      (clk),
        .rst      (rst),
        .accept_i (accept),
        .hold_i   (busy),
        .req_i    (req_i),
        .entry_i  (entry),
        .line_i   (line),
        .stage_o  (stage)
    );

    dcache_execute execute_i (
        .clk        (clk),
        .rst        (rst),
        .stage_i    (stage),
        .mem_rsp_i  (mem_rsp_i),
        .mem_req_o  (mem_req_o),
        .rsp_o      (rsp_o),
        .busy_o     (busy),
        .wr_en_o    (wr_en),
        .wr_index_o (wr_index),
        .wr_entry_o (wr_entry),
        .wr_line_o  (wr_line)
    );

endmodule

//--- dv/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::mem_req_t req_i,
    output dcache_pkg::mem_rsp_t rsp_o
);

    // Backing store covers the low 64 KB, word addressed
    logic [31:0]  mem [16384];
    int           line_writes;
    int           word_accesses;
    int unsigned  wait_cnt;
    logic         pending;
    logic [127:0] rd_line;

    initial begin
        line_writes   = 0;
        word_accesses = 0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= 1'b0;
            if (req_i.valid) begin
                // Read data is captured before a write lands
                for (int k = 0; k < 4; k++) begin
                    rd_line[k*32 +: 32] = mem[{req_i.addr[15:4], k[1:0]}];
                end
                if (req_i.write) begin
                    for (int b = 0; b < 16; b++) begin
                        if (req_i.wstrb[b]) begin
                            mem[{req_i.addr[15:4], b[3:2]}][(b%4)*8 +: 8] = req_i.wdata[b*8 +: 8];
                        end
                    end
                end
                if (req_i.line && req_i.write) begin
                    line_writes++;
                end
                if (!req_i.line) begin
                    word_accesses++;
                end
                pending  <= 1'b1;
                wait_cnt = $urandom_range(1, 6);
            end
            if (pending) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    pending     <= 1'b0;
                    rsp_o.valid <= 1'b1;
                    rsp_o.rdata <= rd_line;
                end
            end
        end
    end

endmodule

//--- dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int N_RAND     = 200;
    localparam int MAX_CYCLES = (N_RAND + 40) * 24 + 200;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] acc;
    } pend_t;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    dcache_pkg::cpu_req_t req;
    logic                 ready;
    dcache_pkg::cpu_rsp_t rsp;
    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_rsp_t mem_rsp;

    logic [31:0]  shadow [16384];
    pend_t        exp_q [$];
    pend_t        head;
    logic [31:0]  exp_word;
    logic [127:0] exp_line;
    logic [31:0]  cyc;
    logic [31:0]  last_lat;
    logic [31:0]  last_addr;
    logic [15:0]  last_wstrb;
    logic         last_write;
    int           errors;
    int           n_acc;
    int           n_rsp;
    int           n_mem;

    dcache_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .ready_o     (ready),
        .rsp_o       (rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    dcache_mem_model mem_i (
        .clk   (clk),
        .rst   (rst),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [127:0] shadow_line(input logic [31:0] addr);
        return {shadow[{addr[15:4], 2'd3}], shadow[{addr[15:4], 2'd2}],
                shadow[{addr[15:4], 2'd1}], shadow[{addr[15:4], 2'd0}]};
    endfunction

    //////////////////////////////////////////////////
    // Response and memory traffic checks
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst) begin
            if (mem_req.valid) begin
                n_mem++;
                if (mem_req.write && mem_req.line) begin
                    // Evicted line must hold every store committed so far
                    exp_line = shadow_line(mem_req.addr);
                    assert (mem_req.wdata == exp_line) else begin
                        $display("[ERROR] %0t mem_req_o.wdata got %h expected %h",
                                 $time, mem_req.wdata, exp_line);
                        errors++;
                    end
                end
                if (!mem_req.line) begin
                    last_addr  = mem_req.addr;
                    last_wstrb = mem_req.wstrb;
                    last_write = mem_req.write;
                end
            end
            if (rsp.valid) begin
                n_rsp++;
                if (exp_q.size() == 0) begin
                    $display("Response strobe at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    head     = exp_q.pop_front();
                    last_lat = cyc - head.acc;
                    if (head.wstrb == 4'h0) begin
                        exp_word = shadow[head.addr[15:2]];
                    end else begin
                        exp_word = 32'h0;
                        for (int b = 0; b < 4; b++) begin
                            if (head.wstrb[b]) begin
                                shadow[head.addr[15:2]][b*8 +: 8] = head.wdata[b*8 +: 8];
                            end
                        end
                    end
                    assert (rsp.rdata == exp_word) else begin
                        $display("[ERROR] %0t rsp_o.rdata got %h expected %h",
                                 $time, rsp.rdata, exp_word);
                        errors++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, input logic unc);
        pend_t p;
        req.addr     = addr;
        req.wdata    = wdata;
        req.wstrb    = wstrb;
        req.uncached = unc;
        req_valid    = 1'b1;
        while (!ready) @(negedge clk);
        p = '{addr: addr, wdata: wdata, wstrb: wstrb, acc: cyc};
        exp_q.push_back(p);
        n_acc++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin : watchdog
        wait (cyc >= MAX_CYCLES);
        $display("Timeout after %0d cycles, a request never completed", cyc);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          e0;
        int          m0;
        int          w0;
        logic [31:0] a;
        logic [3:0]  s;

        void'($urandom(32'h8bc2_4235));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cyc       = '0;
        errors    = 0;
        n_acc     = 0;
        n_rsp     = 0;
        n_mem     = 0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = (i * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Reset state, miss, then a hit on the same line
        e0 = errors;
        assert (ready && !rsp.valid && !mem_req.valid) else begin
            $display("Outputs not idle after reset");
            errors++;
        end
        issue(32'h0000_0100, 32'h0, 4'h0, 1'b0);
        drain();
        m0 = n_mem;
        issue(32'h0000_0104, 32'h0, 4'h0, 1'b0);
        drain();
        assert (last_lat == 32'd2 && n_mem == m0) else begin
            $display("Hit took %0d cycles or went to memory", last_lat);
            errors++;
        end
        report_test("reset_and_hit", e0);

        // Partial and full stores on hits and misses
        e0 = errors;
        issue(32'h0000_3004, 32'h0000_ab00, 4'b0010, 1'b0);
        issue(32'h0000_3008, 32'h1234_0000, 4'b1100, 1'b0);
        issue(32'h0000_3000, 32'hdead_beef, 4'b1111, 1'b0);
        issue(32'h0000_3404, 32'h0000_00c3, 4'b0001, 1'b0);
        for (int i = 0; i < 4; i++) begin
            issue(32'h0000_3000 + i * 4, 32'h0, 4'h0, 1'b0);
        end
        issue(32'h0000_3404, 32'h0, 4'h0, 1'b0);
        drain();
        report_test("store_strobes", e0);

        // Dirty lines in one set force write-backs
        e0 = errors;
        w0 = mem_i.line_writes;
        for (int t = 0; t < 4; t++) begin
            issue(32'h0000_2050 + t * 256, 32'h5000_0000 + t, 4'hf, 1'b0);
        end
        for (int t = 0; t < 6; t++) begin
            issue(32'h0000_2050 + t * 256, 32'h0, 4'h0, 1'b0);
        end
        drain();
        assert (mem_i.line_writes - w0 >= 2) else begin
            $display("Only %0d evictions seen for four dirty lines", mem_i.line_writes - w0);
            errors++;
        end
        report_test("eviction", e0);

        // Uncached word accesses and a backing change between loads
        e0 = errors;
        w0 = mem_i.word_accesses;
        issue(32'h0000_8014, 32'h7788_9900, 4'b0110, 1'b1);
        drain();
        assert (mem_i.word_accesses == w0 + 1 && last_write && last_addr == 32'h0000_8014
                && last_wstrb == 16'h0060) else begin
            $display("Uncached store did not make one matching word write");
            errors++;
        end
        issue(32'h0000_8014, 32'h0, 4'h0, 1'b1);
        drain();
        mem_i.mem[14'h2005] = 32'hcafe_f00d;
        shadow[14'h2005]    = 32'hcafe_f00d;
        issue(32'h0000_8014, 32'h0, 4'h0, 1'b1);
        drain();
        assert (mem_i.word_accesses == w0 + 3 && !last_write && last_addr == 32'h0000_8014
                && last_wstrb == 16'h0) else begin
            $display("Uncached loads did not make one word read each");
            errors++;
        end
        report_test("uncached", e0);

        // Random mix, cached and uncached regions kept apart
        e0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            case ($urandom_range(0, 2))
                0:       s = 4'b0001 << $urandom_range(0, 3);
                1:       s = 4'b0011 << (2 * $urandom_range(0, 1));
                default: s = 4'hf;
            endcase
            if ($urandom_range(0, 1) == 0) begin
                s = 4'h0;
            end
            if ($urandom_range(0, 3) == 0) begin
                a = 32'h0000_8000 + $urandom_range(0, 15) * 4;
                issue(a, $urandom, s, 1'b1);
            end else begin
                a = 32'h0000_1000 + $urandom_range(0, 511) * 4;
                issue(a, $urandom, s, 1'b0);
            end
        end
        drain();
        assert (n_rsp == n_acc) else begin
            $display("Accepted %0d requests but saw %0d responses", n_acc, n_rsp);
            errors++;
        end
        report_test("random_mix", e0);

        $display("tests 5, accepted %0d, responses %0d, errors %0d", n_acc, n_rsp, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_result.sv
rtl/dcache_decode.sv
rtl/dcache_execute.sv
rtl/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
BUILD     ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep "^Verification passed$$" > /dev/null

clean:
	rm -rf $(BUILD)
